// File: verilog/madd_defs.svh
`ifndef MADD_DEFS_SVH
`define MADD_DEFS_SVH

// Sizes of the multiply-add slice
//
// The register count and the address width are kept as two macros.
// MADD_ADDR_W must be wide enough to index MADD_REGS entries.

// Width of one operand, one result and one register word
`define MADD_DATA_W 32

// Number of architectural registers in the array
`define MADD_REGS   32

// Register index width
`define MADD_ADDR_W 5

// Three read ports feed the a, b and c operands
// One write port is shared by writeback and the external load

`endif

// File: verilog/madd_pkg.sv
`default_nettype none

`include "madd_defs.svh"

package madd_pkg;

  // Plain vectors with a meaning
  typedef logic [`MADD_DATA_W-1:0] data_t;     // Operand or result word
  typedef logic [`MADD_ADDR_W-1:0] reg_addr_t; // Register index

  // One issued instruction, rd = rs1 * rs2 + rs3
  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rs3;
    reg_addr_t rd;
  } issue_t;

  // Three operands as read from the array
  typedef struct packed {
    data_t a; // From rs1
    data_t b; // From rs2
    data_t c; // From rs3
  } operands_t;

  // Single write request, used for load, writeback and the array port
  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
    data_t     data;
  } wr_req_t;

  // Bit 0 is port a, bit 1 port b, bit 2 port c
  typedef struct packed {
    logic [2:0] hit;
    data_t      data;
  } bypass_t;

endpackage : madd_pkg

`default_nettype wire

// File: verilog/regfile_3r1w_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "madd_defs.svh"

// Three read ports and one write port, reads are registered.
// A read of the address being written on the same edge returns
// undefined data; the bypass block covers that case.
module regfile_3r1w_sync
  import madd_pkg::*;
  ( input  wire        clk_i

  , input  wr_req_t    w_i         // Write port, valid/addr/data

  , input  wire        rd_v_i      // Read strobe for all three ports
  , input  issue_t     rd_addr_i   // rs1/rs2/rs3 select the words
  , output operands_t  rd_data_o   // Valid one cycle after rd_v_i
  );

  data_t mem_r [`MADD_REGS];       // Register storage, no reset

  data_t rd_a_r;                   // Port 0 read register
  data_t rd_b_r;                   // Port 1 read register
  data_t rd_c_r;                   // Port 2 read register

  // Write port
  always_ff @(posedge clk_i)
  begin
    if (w_i.valid)
    begin
      mem_r[w_i.addr] <= w_i.data;
    end
  end

  // Port 0, operand a
  always_ff @(posedge clk_i)
  begin
    if (rd_v_i)
    begin
      rd_a_r <= mem_r[rd_addr_i.rs1];
    end
  end

  // Port 1, operand b
  always_ff @(posedge clk_i)
  begin
    if (rd_v_i)
    begin
      rd_b_r <= mem_r[rd_addr_i.rs2];
    end
  end

  // Port 2, operand c
  always_ff @(posedge clk_i)
  begin
    if (rd_v_i)
    begin
      rd_c_r <= mem_r[rd_addr_i.rs3];
    end
  end

  // Held until the next read strobe
  assign rd_data_o.a = rd_a_r;
  assign rd_data_o.b = rd_b_r;
  assign rd_data_o.c = rd_c_r;

endmodule : regfile_3r1w_sync

`default_nettype wire

// File: verilog/write_port_bypass.sv
`timescale 1ns/1ps
`default_nettype none

// Owns the single write port of the register array.
// Writeback has priority; a load in the same cycle is dropped.
// Reads that hit the chosen write are flagged for the next stage.
module write_port_bypass
  import madd_pkg::*;
  ( input  wire      clk_i
  , input  wire      arst_n_i

  , input  wr_req_t  wb_i        // Writeback from the combine stage
  , input  wr_req_t  ld_i        // External load

  , input  wire      rd_v_i      // Issue strobe
  , input  issue_t   rd_addr_i   // Source addresses of the issue

  , output wr_req_t  w_o         // To the array write port
  , output bypass_t  byp_o       // Registered hits and data
  , output logic     ld_drop_o   // Pulse after a discarded load
  );

  wr_req_t    w_sel;             // Chosen write request
  logic [2:0] hit_d;             // Per-port collision this cycle
  logic       drop_d;

  logic [2:0] hit_q;
  data_t      byp_data_q;        // Payload, not reset
  logic       drop_q;

  function automatic logic addr_hit(input reg_addr_t ra, input wr_req_t w);
    addr_hit = w.valid && (ra == w.addr);
  endfunction

  // Writeback first, then load
  always_comb
  begin
    if (wb_i.valid)
    begin
      w_sel = wb_i;
    end
    else
    begin
      w_sel = ld_i;
    end
  end

  assign drop_d = wb_i.valid & ld_i.valid;

  // Same-edge read/write collisions on the three ports
  assign hit_d[0] = addr_hit(rd_addr_i.rs1, w_sel);
  assign hit_d[1] = addr_hit(rd_addr_i.rs2, w_sel);
  assign hit_d[2] = addr_hit(rd_addr_i.rs3, w_sel);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      hit_q  <= '0;
      drop_q <= 1'b0;
    end
    else
    begin
      hit_q  <= rd_v_i ? hit_d : 3'b000;  // Only meaningful with a read
      drop_q <= drop_d;
    end
  end

  // Data of the write that the read collided with
  always_ff @(posedge clk_i)
  begin
    if (rd_v_i)
    begin
      byp_data_q <= w_sel.data;
    end
  end

  assign w_o        = w_sel;
  assign byp_o.hit  = hit_q;
  assign byp_o.data = byp_data_q;
  assign ld_drop_o  = drop_q;

endmodule : write_port_bypass

`default_nettype wire

// File: verilog/madd_combine.sv
`timescale 1ns/1ps
`default_nettype none

// Execute stage of the slice.
// Aligns the issue with the registered operands, merges in the
// bypass data and registers rd = a * b + c as a writeback.
module madd_combine
  import madd_pkg::*;
  ( input  wire        clk_i
  , input  wire        arst_n_i

  , input  wire        issue_v_i   // Issue strobe with the read addresses
  , input  reg_addr_t  rd_in_i     // Destination of the issue
  , input  operands_t  ops_i       // From the array one cycle later
  , input  bypass_t    byp_i       // Hits and data aligned with ops_i

  , output wr_req_t    wb_o        // Registered writeback
  );

  logic       ex_v_q;              // Issue delayed to the operand cycle
  reg_addr_t  ex_rd_q;

  data_t      op_a;
  data_t      op_b;
  data_t      op_c;
  data_t      prod;                // Low word of a * b
  data_t      mac_d;

  logic       wb_v_q;
  reg_addr_t  wb_addr_q;
  data_t      wb_data_q;

  function automatic data_t pick(input logic hit, input data_t byp, input data_t rf);
    pick = hit ? byp : rf;
  endfunction

  // Stage 1 control
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ex_v_q <= 1'b0;
    end
    else
    begin
      ex_v_q <= issue_v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (issue_v_i)
    begin
      ex_rd_q <= rd_in_i;
    end
  end

  // Bypass wins the operand select on a hit
  assign op_a = pick(byp_i.hit[0], byp_i.data, ops_i.a);
  assign op_b = pick(byp_i.hit[1], byp_i.data, ops_i.b);
  assign op_c = pick(byp_i.hit[2], byp_i.data, ops_i.c);

  // Unsigned low word only
  assign prod  = op_a * op_b;
  assign mac_d = prod + op_c;

  // Writeback register
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wb_v_q <= 1'b0;
    end
    else
    begin
      wb_v_q <= ex_v_q;                  // Single-cycle pulse per issue
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (ex_v_q)
    begin
      wb_addr_q <= ex_rd_q;
      wb_data_q <= mac_d;
    end
  end

  assign wb_o.valid = wb_v_q;
  assign wb_o.addr  = wb_addr_q;
  assign wb_o.data  = wb_data_q;

endmodule : madd_combine

`default_nettype wire

// File: verilog/madd_core.sv
`timescale 1ns/1ps
`default_nettype none

// Multiply-add slice, rd = rs1 * rs2 + rs3 with a fixed latency of 2.
// No stall and no scoreboard; a consumer issued one cycle after its
// producer sees the old register value.
module madd_core
  import madd_pkg::*;
  ( input  wire      clk_i
  , input  wire      arst_n_i

  , input  wire      issue_v_i
  , input  issue_t   issue_i

  , input  wr_req_t  ld_i          // External register load

  , output logic     result_v_o
  , output wr_req_t  result_o      // Copy of the writeback
  , output logic     ld_drop_o
  );

  wr_req_t   rf_w;                 // Array write port
  operands_t rf_ops;               // Registered read data
  bypass_t   byp;                  // Registered collision info
  wr_req_t   wb;                   // Writeback from execute

  regfile_3r1w_sync u_regfile
    ( .clk_i     (clk_i)
    , .w_i       (rf_w)
    , .rd_v_i    (issue_v_i)
    , .rd_addr_i (issue_i)
    , .rd_data_o (rf_ops)
    );

  write_port_bypass u_write_port_bypass
    ( .clk_i     (clk_i)
    , .arst_n_i  (arst_n_i)
    , .wb_i      (wb)
    , .ld_i      (ld_i)
    , .rd_v_i    (issue_v_i)
    , .rd_addr_i (issue_i)
    , .w_o       (rf_w)
    , .byp_o     (byp)
    , .ld_drop_o (ld_drop_o)
    );

  madd_combine u_madd_combine
    ( .clk_i     (clk_i)
    , .arst_n_i  (arst_n_i)
    , .issue_v_i (issue_v_i)
    , .rd_in_i   (issue_i.rd)
    , .ops_i     (rf_ops)
    , .byp_i     (byp)
    , .wb_o      (wb)
    );

  assign result_o   = wb;
  assign result_v_o = wb.valid;

endmodule : madd_core

`default_nettype wire

// File: testbench/madd_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

// Timing and write port properties of madd_core
module madd_core_checker
  import madd_pkg::*;
  ( input  wire      clk_i
  , input  wire      arst_n_i

  , input  wire      issue_v_i
  , input  wire      result_v_i
  , input  wire      ld_drop_i

  , input  wr_req_t  wb_i        // Writeback from the execute stage
  , input  wr_req_t  ld_i        // External load
  , input  wr_req_t  w_i         // Array write port
  );

  // One result per issue at a fixed latency
  a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_v_i == $past(issue_v_i, 2))
    else $error("result valid does not follow issue by exactly two cycles");

  // A drop needs a writeback and a load on the previous edge
  a_drop_cause: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ld_drop_i |-> $past(wb_i.valid && ld_i.valid))
    else $error("load drop without a colliding writeback and load");

  // Writeback owns the array write port
  a_wb_owns_port: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_i.valid |-> (w_i == wb_i))
    else $error("write port does not carry the valid writeback");

endmodule : madd_core_checker

`default_nettype wire

// File: testbench/madd_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "madd_defs.svh"

module madd_core_tb
  import madd_pkg::*;
  ();

  logic      clk;
  logic      arst_n;
  logic      issue_v;
  issue_t    issue;
  wr_req_t   ld;
  logic      result_v;
  wr_req_t   result;
  logic      ld_drop;

  data_t     model [`MADD_REGS];   // Reference register contents
  int        pend_edge [$];        // Writebacks not yet in the model
  reg_addr_t pend_addr [$];
  data_t     pend_data [$];
  int        exp_edge [$];         // Edge after which result_v_o is seen
  reg_addr_t exp_addr [$];
  data_t     exp_data [$];
  int        drop_edge [$];
  int        edge_n;               // Posedges since reset release
  int        seed;
  int        err_val;
  int        err_other;

  madd_core u_madd_core
    ( .clk_i      (clk)
    , .arst_n_i   (arst_n)
    , .issue_v_i  (issue_v)
    , .issue_i    (issue)
    , .ld_i       (ld)
    , .result_v_o (result_v)
    , .result_o   (result)
    , .ld_drop_o  (ld_drop)
    );

  bind madd_core madd_core_checker u_madd_core_checker
    ( .clk_i      (clk_i)
    , .arst_n_i   (arst_n_i)
    , .issue_v_i  (issue_v_i)
    , .result_v_i (result_v_o)
    , .ld_drop_i  (ld_drop_o)
    , .wb_i       (wb)
    , .ld_i       (ld_i)
    , .w_i        (rf_w)
    );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;        // 100 ns period
  end

  task automatic check_val(input string name, input data_t got, input data_t exp);
    assert (got === exp)
    else
    begin
      err_val++;
      $display("mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // Let one posedge pass, then compare what it produced
  task automatic advance();
    logic exp_v;
    logic exp_drop;
    @(negedge clk);
    edge_n++;
    exp_v = (exp_edge.size() > 0) && (exp_edge[0] == edge_n);
    check_val("result_v_o", 32'(result_v), 32'(exp_v));
    check_val("result_o.valid", 32'(result.valid), 32'(exp_v));
    if (exp_v)
    begin
      check_val("result_o.addr", 32'(result.addr), 32'(exp_addr.pop_front()));
      check_val("result_o.data", result.data, exp_data.pop_front());
      void'(exp_edge.pop_front());
    end
    exp_drop = (drop_edge.size() > 0) && (drop_edge[0] == edge_n);
    check_val("ld_drop_o", 32'(ld_drop), 32'(exp_drop));
    if (exp_drop)
    begin
      void'(drop_edge.pop_front());
    end
    issue_v  = 1'b0;               // Idle unless the next cycle drives again
    ld.valid = 1'b0;
  endtask

  // Drive the next edge and update the model in write order
  task automatic cycle(input logic do_iss, input issue_t iss, input logic do_ld,
                       input reg_addr_t la, input data_t ld_d);
    int        e;
    logic      wb_here;
    reg_addr_t a;
    e = edge_n + 1;
    wb_here = 1'b0;
    while (pend_edge.size() > 0 && pend_edge[0] <= e)
    begin
      wb_here = 1'b1;
      a = pend_addr.pop_front();
      model[a] = pend_data.pop_front();
      void'(pend_edge.pop_front());
    end
    if (do_ld)
    begin
      ld.valid = 1'b1;
      ld.addr  = la;
      ld.data  = ld_d;
      if (wb_here)
        drop_edge.push_back(e);    // Writeback owns the port
      else
        model[la] = ld_d;
    end
    if (do_iss)
    begin
      issue_v = 1'b1;
      issue   = iss;
      pend_edge.push_back(e + 2);
      pend_addr.push_back(iss.rd);
      pend_data.push_back(model[iss.rs1] * model[iss.rs2] + model[iss.rs3]); // Low 32 bits
      exp_edge.push_back(e + 1);
      exp_addr.push_back(iss.rd);
      exp_data.push_back(pend_data[$]);
    end
    advance();
  endtask

  task automatic idle(input int n);
    repeat (n) cycle(1'b0, '0, 1'b0, '0, '0);
  endtask

  function automatic issue_t make_issue(input int s1, input int s2, input int s3, input int d);
    issue_t i;
    i.rs1 = reg_addr_t'(s1);
    i.rs2 = reg_addr_t'(s2);
    i.rs3 = reg_addr_t'(s3);
    i.rd  = reg_addr_t'(d);
    return i;
  endfunction

  // Idle until every expected result, drop and write has happened
  task automatic drain();
    int n;
    n = 0;
    while ((exp_edge.size() + drop_edge.size() + pend_edge.size()) > 0 && n < 20)
    begin
      idle(1);
      n++;
    end
    assert ((exp_edge.size() + drop_edge.size() + pend_edge.size()) == 0)
    else
    begin
      err_other++;
      $display("timeout while waiting for expected results or load drops");
    end
  endtask

  task automatic load_then_isolated_issues();
    int r;
    for (r = 0; r < `MADD_REGS; r++)
      cycle(1'b0, '0, 1'b1, reg_addr_t'(r), $random(seed));
    for (r = 0; r < 4; r++)
    begin
      cycle(1'b1, make_issue($random(seed), $random(seed), $random(seed), $random(seed)),
            1'b0, '0, '0);
      idle(3);
    end
    drain();
  endtask

  task automatic issue_back_to_back();
    int r;
    for (r = 0; r < 6; r++)
      cycle(1'b1, make_issue(r, r + 1, r + 2, 16 + r), 1'b0, '0, '0);
    drain();
  endtask

  task automatic issue_dependent();
    cycle(1'b1, make_issue(1, 2, 3, 8), 1'b0, '0, '0);
    idle(1);
    cycle(1'b1, make_issue(8, 8, 8, 9), 1'b0, '0, '0);     // New value by bypass
    drain();
    cycle(1'b1, make_issue(4, 5, 6, 10), 1'b0, '0, '0);
    cycle(1'b1, make_issue(10, 10, 10, 11), 1'b0, '0, '0); // Old value of r10
    drain();
  endtask

  task automatic collide_load_with_writeback();
    cycle(1'b1, make_issue(1, 2, 3, 12), 1'b0, '0, '0);
    idle(1);
    cycle(1'b0, '0, 1'b1, 5'd12, $random(seed));           // Meets the writeback
    cycle(1'b1, make_issue(12, 12, 12, 13), 1'b0, '0, '0);
    drain();
    cycle(1'b1, make_issue(14, 14, 0, 15), 1'b1, 5'd14, $random(seed));
    drain();
  endtask

  initial
  begin
    seed      = 32'hdfa20319;
    err_val   = 0;
    err_other = 0;
    edge_n    = 0;
    arst_n    = 1'b0;
    issue_v   = 1'b0;
    issue     = '0;
    ld        = '0;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    load_then_isolated_issues();
    issue_back_to_back();
    issue_dependent();
    collide_load_with_writeback();
    $display("Done: %0d value mismatches, %0d other errors", err_val, err_other);
    if (err_val + err_other == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : madd_core_tb

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/madd_pkg.sv
verilog/regfile_3r1w_sync.sv
verilog/write_port_bypass.sv
verilog/madd_combine.sv
verilog/madd_core.sv
testbench/madd_core_checker.sv
testbench/madd_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the madd_core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module madd_core_tb \
  -f src.f \
  -o madd_core_sim

./obj_dir/madd_core_sim 2>&1 | tee "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation finished cleanly"
